// ==== files.f ====
+incdir+source
source/rv_pkg.sv
source/instr_issue.sv
source/instr_buffer.sv
source/imm_extender.sv
source/decode_front_top.sv
tests/decode_front_asserts.sv
tests/decode_front_tb.sv

// ==== tests/decode_front_tb.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module decode_front_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int RAND_WORDS   = 200;
    localparam int BP_WORDS     = `RV_BUF_DEPTH + 1 + 4;   // Accepted words plus stalled probes
    localparam int TOTAL_WORDS  = 12 + 9 + 4 + BP_WORDS + RAND_WORDS;
    localparam int WATCHDOG_CYC = TOTAL_WORDS * 20 + 100;

    logic              clk;
    logic              arst_n;
    logic              in_valid;
    rv_pkg::instr_t    in_instr;
    logic              in_ready;
    logic              out_ready;
    logic              out_valid;
    rv_pkg::imm_fmt_e  out_fmt;
    rv_pkg::word_t     out_imm;
    rv_pkg::mem_size_e out_size;
    logic              out_illegal;

    rv_pkg::instr_t stim_q[$];                         // Words for the next stream
    rv_pkg::instr_t exp_q[$];                          // Accepted words whose results are pending

    decode_front_top u_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .in_ready    (in_ready),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_fmt     (out_fmt),
        .out_imm     (out_imm),
        .out_size    (out_size),
        .out_illegal (out_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog sized from the total word count
    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        fail_run($sformatf("Run hung, tests not done after %0d cycles", WATCHDOG_CYC));
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_word(input string name, input rv_pkg::word_t exp,
                              input rv_pkg::word_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act));
        end
    endtask

    task automatic check_fmt(input string name, input rv_pkg::imm_fmt_e exp,
                             input rv_pkg::imm_fmt_e act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR at %0t: %s expected %s, got %s (%h)",
                               $time, name, exp.name(), act.name(), act));
        end
    endtask

    task automatic check_size(input string name, input rv_pkg::mem_size_e exp,
                              input rv_pkg::mem_size_e act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR at %0t: %s expected %s, got %s (%h)",
                               $time, name, exp.name(), act.name(), act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act));
        end
    endtask

    // Reference model of the decode rules
    function automatic bit is_known(input rv_pkg::instr_t w);
        case (w[6:0])
            rv_pkg::OPC_LOAD, rv_pkg::OPC_STORE, rv_pkg::OPC_BRANCH, rv_pkg::OPC_JALR,
            rv_pkg::OPC_JAL, rv_pkg::OPC_OP_IMM, rv_pkg::OPC_OP, rv_pkg::OPC_LUI,
            rv_pkg::OPC_AUIPC, rv_pkg::OPC_SYSTEM: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic rv_pkg::imm_fmt_e ref_fmt(input rv_pkg::instr_t w);
        case (w[6:0])
            rv_pkg::OPC_LOAD, rv_pkg::OPC_OP_IMM,
            rv_pkg::OPC_JALR, rv_pkg::OPC_SYSTEM: return rv_pkg::FMT_I;
            rv_pkg::OPC_STORE:                    return rv_pkg::FMT_S;
            rv_pkg::OPC_BRANCH:                   return rv_pkg::FMT_B;
            rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC:   return rv_pkg::FMT_U;
            rv_pkg::OPC_JAL:                      return rv_pkg::FMT_J;
            default:                              return rv_pkg::FMT_NONE;
        endcase
    endfunction

    // Field packed at the top and shifted down arithmetically
    function automatic rv_pkg::word_t ref_imm(input rv_pkg::instr_t w);
        logic signed [31:0] v;
        case (ref_fmt(w))
            rv_pkg::FMT_I: v = $signed(w) >>> 20;
            rv_pkg::FMT_S: v = $signed({w[31:25], w[11:7], 20'b0}) >>> 20;
            rv_pkg::FMT_B: v = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0, 19'b0}) >>> 19;
            rv_pkg::FMT_U: v = {w[31:12], 12'b0};
            rv_pkg::FMT_J: v = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0, 11'b0}) >>> 11;
            default:       v = '0;
        endcase
        return v;
    endfunction

    function automatic rv_pkg::mem_size_e ref_size(input rv_pkg::instr_t w);
        if (w[6:0] != rv_pkg::OPC_LOAD && w[6:0] != rv_pkg::OPC_STORE) begin
            return rv_pkg::SIZE_NA;
        end
        case (w[13:12])
            2'd0:    return rv_pkg::SIZE_BYTE;
            2'd1:    return rv_pkg::SIZE_HALF;
            2'd2:    return rv_pkg::SIZE_WORD;
            default: return rv_pkg::SIZE_NA;
        endcase
    endfunction

    function automatic logic ref_illegal(input rv_pkg::instr_t w);
        logic mem;
        mem = (w[6:0] == rv_pkg::OPC_LOAD) || (w[6:0] == rv_pkg::OPC_STORE);
        return !is_known(w) || (mem && w[13:12] == 2'd3);
    endfunction

    // Encoders with fixed registers rd 1, rs1 5, rs2 6
    function automatic rv_pkg::instr_t enc_i(input logic [11:0] imm, input logic [6:0] opc,
                                             input logic [2:0] f3);
        return {imm, 5'd5, f3, 5'd1, opc};
    endfunction

    function automatic rv_pkg::instr_t enc_s(input logic [11:0] imm, input logic [2:0] f3);
        return {imm[11:5], 5'd6, 5'd5, f3, imm[4:0], rv_pkg::OPC_STORE};
    endfunction

    function automatic rv_pkg::instr_t enc_b(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd6, 5'd5, 3'b001, imm[4:1], imm[11], rv_pkg::OPC_BRANCH};
    endfunction

    function automatic rv_pkg::instr_t enc_u(input logic [19:0] imm, input logic [6:0] opc);
        return {imm, 5'd1, opc};
    endfunction

    function automatic rv_pkg::instr_t enc_j(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, rv_pkg::OPC_JAL};
    endfunction

    function automatic rv_pkg::instr_t random_word();
        rv_pkg::opcode_e op;
        rv_pkg::instr_t  w;
        op = op.first();
        repeat ($urandom_range(9)) begin
            op = op.next();
        end
        w      = $urandom;
        w[6:0] = op;                                   // Valid opcode over random fields
        return w;
    endfunction

    task automatic check_result();
        rv_pkg::instr_t w;
        if (exp_q.size() == 0) begin
            fail_run("Output became valid with no accepted word outstanding");
        end else begin
            w = exp_q.pop_front();
            check_fmt("out_fmt", ref_fmt(w), out_fmt);
            check_word("out_imm", ref_imm(w), out_imm);
            check_size("out_size", ref_size(w), out_size);
            check_flag("out_illegal", ref_illegal(w), out_illegal);
        end
    endtask

    // Called and returns at a falling edge
    task automatic drive_stream(input bit gaps);
        foreach (stim_q[i]) begin
            while (gaps && $urandom_range(3) == 0) begin
                in_valid = 1'b0;                       // Idle cycle
                @(negedge clk);
            end
            in_valid = 1'b1;
            in_instr = stim_q[i];
            while (!in_ready) begin
                @(negedge clk);
            end
            exp_q.push_back(stim_q[i]);                // Taken at the next rising edge
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_results(input int n, input bit rand_ready);
        int got;
        got = 0;
        while (got < n) begin
            out_ready = rand_ready ? 1'($urandom_range(1)) : 1'b1;
            if (out_valid && out_ready) begin
                check_result();                        // Result leaves at the next rising edge
                got++;
            end
            @(negedge clk);
        end
        out_ready = 1'b0;
    endtask

    task automatic run_stream(input bit gaps, input bit rand_ready);
        int n;
        n = stim_q.size();
        fork
            drive_stream(gaps);
            collect_results(n, rand_ready);
        join
        stim_q.delete();
    endtask

    task automatic test_reset();
        check_flag("in_ready", 1'b1, in_ready);
        check_flag("out_valid", 1'b0, out_valid);
    endtask

    task automatic test_formats();
        stim_q.push_back(enc_i(12'h123, rv_pkg::OPC_OP_IMM, 3'b000));
        stim_q.push_back(enc_i(12'h876, rv_pkg::OPC_OP_IMM, 3'b000));
        stim_q.push_back(enc_i(12'hfff, rv_pkg::OPC_JALR, 3'b000));
        stim_q.push_back(enc_i(12'h001, rv_pkg::OPC_SYSTEM, 3'b000));
        stim_q.push_back(enc_s(12'h2a5, 3'b010));
        stim_q.push_back(enc_s(12'hc3a, 3'b000));
        stim_q.push_back(enc_b(13'h0a4c));
        stim_q.push_back(enc_b(13'h1f36));
        stim_q.push_back(enc_u(20'h12345, rv_pkg::OPC_LUI));
        stim_q.push_back(enc_u(20'hfedcb, rv_pkg::OPC_AUIPC));
        stim_q.push_back(enc_j(21'h05a6e));
        stim_q.push_back(enc_j(21'h1a5c34));
        run_stream(1'b0, 1'b0);
    endtask

    task automatic test_sizes();
        for (int f = 0; f < 4; f++) begin
            stim_q.push_back(enc_i(12'h7f0 ^ 12'(f), rv_pkg::OPC_LOAD, 3'(f)));
            stim_q.push_back(enc_s(12'h805 + 12'(f), 3'(f)));
        end
        stim_q.push_back(enc_i(12'h123, rv_pkg::OPC_OP_IMM, 3'b010));  // Not a memory access
        run_stream(1'b0, 1'b0);
    endtask

    task automatic test_unknown();
        stim_q.push_back({7'h20, 5'd6, 5'd5, 3'b000, 5'd1, rv_pkg::OPC_OP});
        stim_q.push_back(32'hfff0_000f);               // MISC_MEM lies outside the set
        stim_q.push_back(32'h8000_007f);
        stim_q.push_back(32'h1234_5600);
        run_stream(1'b0, 1'b0);
    endtask

    task automatic test_back_pressure();
        int             accepted;
        int             stalled;
        rv_pkg::instr_t w;
        accepted  = 0;
        stalled   = 0;
        out_ready = 1'b0;
        while (stalled < 4) begin
            if (in_ready) begin
                w        = random_word();
                in_valid = 1'b1;
                in_instr = w;
                exp_q.push_back(w);
                accepted++;
                stalled  = 0;
            end else begin
                stalled++;                             // Word stays offered but is not taken
            end
            if (accepted > `RV_BUF_DEPTH + 1) begin
                fail_run("Back-pressure let in more words than buffer and output can hold");
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
        check_flag("in_ready", 1'b0, in_ready);
        check_flag("out_valid", 1'b1, out_valid);
        collect_results(accepted, 1'b0);
    endtask

    task automatic test_random();
        repeat (RAND_WORDS) begin
            stim_q.push_back(random_word());
        end
        run_stream(1'b1, 1'b1);
    endtask

    initial begin
        void'($urandom(32'h9ea8));
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_instr  = '0;
        out_ready = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        test_reset();
        @(negedge clk);
        test_formats();
        test_sizes();
        test_unknown();
        test_back_pressure();
        test_random();
        if (exp_q.size() != 0) begin
            fail_run("Accepted words never came out of the DUT");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// ==== tests/decode_front_asserts.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module decode_front_asserts (
    input logic              clk,
    input logic              arst_n,
    input logic              in_ready,
    input logic              buf_push,
    input logic              buf_valid,
    input logic              buf_pop,
    input logic              out_ready,
    input logic              out_valid,
    input rv_pkg::imm_fmt_e  out_fmt,
    input rv_pkg::word_t     out_imm,
    input rv_pkg::mem_size_e out_size,
    input logic              out_illegal
);

    logic [`RV_CREDIT_W-1:0] held;                     // Occupancy rebuilt from the link strobes

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            held <= '0;
        end else begin
            held <= held + `RV_CREDIT_W'(buf_push) - `RV_CREDIT_W'(buf_pop);
        end
    end

    // Credits never outnumber the free slots
    ready_needs_free_slot: assert property (@(posedge clk) disable iff (!arst_n)
        in_ready |-> held < `RV_BUF_DEPTH)
        else $error("in_ready high while the buffer is full");

    pop_needs_word: assert property (@(posedge clk) disable iff (!arst_n)
        buf_pop |-> held != '0)
        else $error("Buffer pop while no word is held");

    valid_tracks_count: assert property (@(posedge clk) disable iff (!arst_n)
        buf_valid == (held != '0))
        else $error("buf_valid disagrees with the words pushed and popped");

    // A stalled result stays offered
    out_valid_held: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid)
        else $error("out_valid dropped while out_ready was low");

    out_payload_held: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> $stable(out_fmt) && $stable(out_imm) &&
                                    $stable(out_size) && $stable(out_illegal))
        else $error("Output result changed while out_ready was low");

endmodule

bind decode_front_top decode_front_asserts u_asserts (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_ready    (in_ready),
    .buf_push    (buf_push),
    .buf_valid   (buf_valid),
    .buf_pop     (buf_pop),
    .out_ready   (out_ready),
    .out_valid   (out_valid),
    .out_fmt     (out_fmt),
    .out_imm     (out_imm),
    .out_size    (out_size),
    .out_illegal (out_illegal)
);

// ==== source/decode_front_top.sv ====
`timescale 1ns/100ps

module decode_front_top (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              in_valid,
    input  rv_pkg::instr_t    in_instr,
    output logic              in_ready,
    input  logic              out_ready,
    output logic              out_valid,
    output rv_pkg::imm_fmt_e  out_fmt,
    output rv_pkg::word_t     out_imm,
    output rv_pkg::mem_size_e out_size,
    output logic              out_illegal
);

    logic           buf_push;                          // Issue to buffer, credit covered
    rv_pkg::instr_t buf_instr;
    logic           credit_return;                     // Buffer back to issue
    logic           buf_valid;
    rv_pkg::instr_t buf_head;
    logic           buf_pop;

    instr_issue u_issue (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_valid      (in_valid),
        .in_instr      (in_instr),
        .in_ready      (in_ready),
        .buf_push      (buf_push),
        .buf_instr     (buf_instr),
        .credit_return (credit_return)
    );

    instr_buffer u_buffer (
        .clk           (clk),
        .arst_n        (arst_n),
        .buf_push      (buf_push),
        .buf_instr     (buf_instr),
        .buf_pop       (buf_pop),
        .buf_valid     (buf_valid),
        .buf_head      (buf_head),
        .credit_return (credit_return)
    );

    imm_extender u_extend (
        .clk         (clk),
        .arst_n      (arst_n),
        .buf_valid   (buf_valid),
        .buf_head    (buf_head),
        .buf_pop     (buf_pop),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_fmt     (out_fmt),
        .out_imm     (out_imm),
        .out_size    (out_size),
        .out_illegal (out_illegal)
    );

endmodule

// ==== source/imm_extender.sv ====
`timescale 1ns/100ps

module imm_extender (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              buf_valid,
    input  rv_pkg::instr_t    buf_head,
    output logic              buf_pop,
    input  logic              out_ready,
    output logic              out_valid,
    output rv_pkg::imm_fmt_e  out_fmt,
    output rv_pkg::word_t     out_imm,
    output rv_pkg::mem_size_e out_size,
    output logic              out_illegal
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic              sign;                           // Bit 31, sign of every immediate
    rv_pkg::imm_fmt_e  fmt_d;
    rv_pkg::word_t     imm_d;
    rv_pkg::mem_size_e size_d;
    logic              illegal_d;

    assign opcode = buf_head[6:0];
    assign funct3 = buf_head[14:12];
    assign sign   = buf_head[31];

    // Take the head when the output slot is free or emptied this cycle
    assign buf_pop = buf_valid & (~out_valid | out_ready);

    // Opcode to format, access size and legality
    always_comb begin
        fmt_d     = rv_pkg::FMT_NONE;
        size_d    = rv_pkg::SIZE_NA;
        illegal_d = 1'b0;
        case (opcode)
            rv_pkg::OPC_LOAD,
            rv_pkg::OPC_STORE: begin
                fmt_d  = (opcode == rv_pkg::OPC_STORE) ? rv_pkg::FMT_S : rv_pkg::FMT_I;
                size_d = rv_pkg::mem_size_e'(funct3[1:0]);          // Same encoding
                illegal_d = (funct3[1:0] == 2'b11);                 // Reserved size
            end
            rv_pkg::OPC_OP_IMM,
            rv_pkg::OPC_JALR,
            rv_pkg::OPC_SYSTEM: fmt_d = rv_pkg::FMT_I;
            rv_pkg::OPC_BRANCH: fmt_d = rv_pkg::FMT_B;
            rv_pkg::OPC_LUI,
            rv_pkg::OPC_AUIPC:  fmt_d = rv_pkg::FMT_U;
            rv_pkg::OPC_JAL:    fmt_d = rv_pkg::FMT_J;
            rv_pkg::OPC_OP:     fmt_d = rv_pkg::FMT_NONE;           // Register form
            default:            illegal_d = 1'b1;                   // Unknown opcode
        endcase
    end

    // Immediate assembly by RV32I bit layout
    always_comb begin
        case (fmt_d)
            rv_pkg::FMT_I: imm_d = {{20{sign}}, buf_head[31:20]};
            rv_pkg::FMT_S: imm_d = {{20{sign}}, buf_head[31:25], buf_head[11:7]};
            rv_pkg::FMT_B: imm_d = {{19{sign}}, sign, buf_head[7], buf_head[30:25],
                                    buf_head[11:8], 1'b0};          // Even offset
            rv_pkg::FMT_U: imm_d = {buf_head[31:12], 12'b0};        // Upper 20 bits
            rv_pkg::FMT_J: imm_d = {{11{sign}}, sign, buf_head[19:12], buf_head[20],
                                    buf_head[30:21], 1'b0};
            default:       imm_d = '0;
        endcase
    end

    // Output valid, held until taken
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (buf_pop) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;                         // Taken, nothing new behind it
        end
    end

    // Result payload, loaded only on a pop so it is stable under back-pressure
    always_ff @(posedge clk) begin
        if (buf_pop) begin
            out_fmt     <= fmt_d;
            out_imm     <= imm_d;
            out_size    <= size_d;
            out_illegal <= illegal_d;
        end
    end

endmodule

// ==== source/instr_buffer.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module instr_buffer (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           buf_push,
    input  rv_pkg::instr_t buf_instr,
    input  logic           buf_pop,
    output logic           buf_valid,
    output rv_pkg::instr_t buf_head,
    output logic           credit_return
);

    localparam int PTR_W = $clog2(`RV_BUF_DEPTH);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(`RV_BUF_DEPTH - 1);

    rv_pkg::instr_t          mem [`RV_BUF_DEPTH];      // Word storage
    logic [PTR_W-1:0]        wr_ptr;
    logic [PTR_W-1:0]        rd_ptr;
    logic [`RV_CREDIT_W-1:0] count;                    // Words held
    logic                    do_pop;

    assign buf_valid = (count != '0);
    assign buf_head  = mem[rd_ptr];                    // Oldest word presented combinationally
    assign do_pop    = buf_pop & buf_valid;            // Ignore a pop on an empty buffer

    // The credit loop keeps every push within a free slot
    always_ff @(posedge clk) begin
        if (buf_push) begin
            mem[wr_ptr] <= buf_instr;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (buf_push) begin
                wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;   // Circular wrap
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            end
            case ({buf_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                            // Push and pop together
            endcase
            credit_return <= do_pop;                   // One registered pulse per freed slot
        end
    end

endmodule

// ==== source/instr_issue.sv ====
`timescale 1ns/100ps
`include "rv_consts.svh"

module instr_issue (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           in_valid,
    input  rv_pkg::instr_t in_instr,
    output logic           in_ready,
    output logic           buf_push,
    output rv_pkg::instr_t buf_instr,
    input  logic           credit_return
);

    logic [`RV_CREDIT_W-1:0] credits;                  // Free slots known to be in the buffer

    assign in_ready  = (credits != '0);                // Accept only while a slot is guaranteed
    assign buf_push  = in_valid & in_ready;            // Push in the cycle of the handshake
    assign buf_instr = in_instr;                       // Word goes on unchanged

    // Spend one credit per push, regain one per returned pulse
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits <= `RV_CREDIT_W'(`RV_BUF_DEPTH);  // Buffer starts empty
        end else begin
            case ({buf_push, credit_return})
                2'b10:   credits <= credits - 1'b1;    // Push only
                2'b01:   credits <= credits + 1'b1;    // Return only
                default: credits <= credits;           // None, or both cancel out
            endcase
        end
    end

endmodule

// ==== source/rv_pkg.sv ====
`include "rv_consts.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] instr_t;   // Raw instruction word
    typedef logic [`RV_XLEN-1:0] word_t;    // Data word, e.g. an extended immediate

    // RV32I major opcodes, bits 6 to 0 of the instruction
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b000_0011,
        OPC_STORE  = 7'b010_0011,
        OPC_BRANCH = 7'b110_0011,
        OPC_JALR   = 7'b110_0111,
        OPC_JAL    = 7'b110_1111,
        OPC_OP_IMM = 7'b001_0011,
        OPC_OP     = 7'b011_0011,
        OPC_LUI    = 7'b011_0111,
        OPC_AUIPC  = 7'b001_0111,
        OPC_SYSTEM = 7'b111_0011
    } opcode_e;

    // Immediate layout of an instruction
    typedef enum logic [2:0] {
        FMT_NONE = 3'd0,                    // No immediate, value is zero
        FMT_I    = 3'd1,
        FMT_S    = 3'd2,
        FMT_B    = 3'd3,
        FMT_U    = 3'd4,
        FMT_J    = 3'd5
    } imm_fmt_e;

    // Load and store access size, encoded like funct3[1:0]
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2,
        SIZE_NA   = 2'd3                    // Not a memory access, or reserved size
    } mem_size_e;

endpackage

// ==== source/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Data and instruction word width
`define RV_XLEN 32

// Buffer slots, also the credit count the producer starts with
`define RV_BUF_DEPTH 4

// Wide enough to hold the value RV_BUF_DEPTH
`define RV_CREDIT_W 3

`endif
